// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int WORD_W = 32;
    localparam int NUM_REGS = 32;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [2*WORD_W-1:0] cnt_t;

    // Register zero is hardwired, never written or forwarded
    localparam reg_addr_t REG_ZERO = 5'd0;

    // Instruction field positions
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 26;
    localparam int RD_HI = 25;
    localparam int RD_LO = 21;
    localparam int RS1_HI = 20;
    localparam int RS1_LO = 16;
    localparam int RS2_HI = 15;
    localparam int RS2_LO = 11;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

    localparam int IMM_W = IMM_HI - IMM_LO + 1;
    localparam int SHAMT_W = 5;

    // Any code not listed here is illegal
    typedef enum logic [5:0] {
        OP_ADD      = 6'h01,
        OP_SUB      = 6'h02,
        OP_AND      = 6'h03,
        OP_OR       = 6'h04,
        OP_XOR      = 6'h05,
        OP_SLL      = 6'h06,
        OP_SRL      = 6'h07,
        OP_ADDI     = 6'h08,
        OP_LUI      = 6'h09,
        OP_ST       = 6'h0a,
        OP_RDCNT_LO = 6'h0b,
        OP_RDCNT_HI = 6'h0c
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

// File: common/pipe_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_exe_if;
    import pipe_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     instr;
    alu_op_e   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    // Port B source, rd for stores
    reg_addr_t rs2;
    word_t     op_a;
    word_t     op_b;
    word_t     imm;
    logic      use_imm;
    logic      writes_rd;
    logic      is_store;
    logic      is_cnt_hi;
    logic      is_cnt_lo;
    logic      excp;

    modport src (
        output valid, pc, instr, alu_op, rd, rs1, rs2, op_a, op_b, imm,
        output use_imm, writes_rd, is_store, is_cnt_hi, is_cnt_lo, excp
    );
    modport snk (
        input valid, pc, instr, alu_op, rd, rs1, rs2, op_a, op_b, imm,
        input use_imm, writes_rd, is_store, is_cnt_hi, is_cnt_lo, excp
    );
endinterface

interface exe_wb_if;
    import pipe_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     instr;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
    logic      is_store;
    word_t     st_addr;
    word_t     st_data;
    logic      excp;

    modport src (output valid, pc, instr, we, waddr, wdata, is_store, st_addr, st_data, excp);
    modport snk (input valid, pc, instr, we, waddr, wdata, is_store, st_addr, st_data, excp);
endinterface

interface fwd_if;
    import pipe_pkg::*;

    logic      valid;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    modport src (output valid, we, waddr, wdata);
    modport snk (input valid, we, waddr, wdata);
endinterface

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  pipe_pkg::reg_addr_t raddr_a_i,
    input  pipe_pkg::reg_addr_t raddr_b_i,
    output pipe_pkg::word_t     rdata_a_o,
    output pipe_pkg::word_t     rdata_b_o,
    input  logic                we_i,
    input  pipe_pkg::reg_addr_t waddr_i,
    input  pipe_pkg::word_t     wdata_i
);
    import pipe_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != REG_ZERO) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Entry zero is cleared by reset and never written
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  logic                instr_valid_i,
    input  pipe_pkg::word_t     instr_i,
    input  pipe_pkg::word_t     pc_i,
    output pipe_pkg::reg_addr_t rf_raddr_a_o,
    output pipe_pkg::reg_addr_t rf_raddr_b_o,
    input  pipe_pkg::word_t     rf_rdata_a_i,
    input  pipe_pkg::word_t     rf_rdata_b_i,
    dec_exe_if.src              dec_o
);
    import pipe_pkg::*;

    opcode_e          opcode;
    reg_addr_t        rd;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    logic [IMM_W-1:0] imm16;
    word_t            imm;
    alu_op_e          alu_op;
    logic             use_imm;
    logic             writes_rd;
    logic             is_store;
    logic             is_cnt_lo;
    logic             is_cnt_hi;
    logic             excp;

    assign opcode = opcode_e'(instr_i[OPC_HI:OPC_LO]);
    assign rd = instr_i[RD_HI:RD_LO];
    assign rs1 = instr_i[RS1_HI:RS1_LO];
    assign rs2 = instr_i[RS2_HI:RS2_LO];
    assign imm16 = instr_i[IMM_HI:IMM_LO];

    always_comb begin
        alu_op = ALU_ADD;
        imm = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
        use_imm = 1'b0;
        writes_rd = 1'b1;
        is_store = 1'b0;
        is_cnt_lo = 1'b0;
        is_cnt_hi = 1'b0;
        excp = 1'b0;
        case (opcode)
            OP_ADD: alu_op = ALU_ADD;
            OP_SUB: alu_op = ALU_SUB;
            OP_AND: alu_op = ALU_AND;
            OP_OR: alu_op = ALU_OR;
            OP_XOR: alu_op = ALU_XOR;
            OP_SLL: alu_op = ALU_SLL;
            OP_SRL: alu_op = ALU_SRL;
            OP_ADDI: use_imm = 1'b1;
            OP_LUI: begin
                alu_op = ALU_PASS_B;
                imm = {imm16, {(WORD_W-IMM_W){1'b0}}};
                use_imm = 1'b1;
            end
            // Address is rs1 + imm, data comes from rd
            OP_ST: begin
                use_imm = 1'b1;
                writes_rd = 1'b0;
                is_store = 1'b1;
            end
            OP_RDCNT_LO: is_cnt_lo = 1'b1;
            OP_RDCNT_HI: is_cnt_hi = 1'b1;
            default: begin
                writes_rd = 1'b0;
                excp = 1'b1;
            end
        endcase
    end

    assign rf_raddr_a_o = rs1;
    assign rf_raddr_b_o = is_store ? rd : rs2;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            dec_o.valid <= 1'b0;
            dec_o.use_imm <= 1'b0;
            dec_o.writes_rd <= 1'b0;
            dec_o.is_store <= 1'b0;
            dec_o.is_cnt_lo <= 1'b0;
            dec_o.is_cnt_hi <= 1'b0;
            dec_o.excp <= 1'b0;
        end else begin
            dec_o.valid <= instr_valid_i;
            dec_o.use_imm <= use_imm;
            dec_o.writes_rd <= writes_rd;
            dec_o.is_store <= is_store;
            dec_o.is_cnt_lo <= is_cnt_lo;
            dec_o.is_cnt_hi <= is_cnt_hi;
            dec_o.excp <= excp;
        end
    end

    always_ff @(posedge clk) begin
        dec_o.pc <= pc_i;
        dec_o.instr <= instr_i;
        dec_o.alu_op <= alu_op;
        dec_o.rd <= rd;
        dec_o.rs1 <= rs1;
        dec_o.rs2 <= rf_raddr_b_o;
        dec_o.op_a <= rf_rdata_a_i;
        dec_o.op_b <= rf_rdata_b_i;
        dec_o.imm <= imm;
    end

    a_excp_no_write: assert property (@(posedge clk) disable iff (rst)
        dec_o.valid && dec_o.excp |-> !dec_o.writes_rd);

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush_i,
    dec_exe_if.snk dec_i,
    exe_wb_if.src  wb_o,
    fwd_if.src     exe_fwd_o,
    fwd_if.snk     wb_fwd_i
);
    import pipe_pkg::*;

    cnt_t      cycle_cnt;
    word_t     opa;
    word_t     opb;
    word_t     alu_b;
    word_t     alu_res;
    word_t     exe_wdata;

    logic      valid_q;
    logic      we_q;
    logic      excp_q;
    logic      store_q;
    logic      cnt_lo_q;
    logic      cnt_hi_q;
    word_t     pc_q;
    word_t     instr_q;
    reg_addr_t waddr_q;
    word_t     res_q;
    word_t     st_data_q;

    function automatic logic fwd_hit(input logic valid, input logic we,
                                     input reg_addr_t waddr, input reg_addr_t src);
        return valid && we && waddr == src && waddr != REG_ZERO;
    endfunction

    // Nearer instruction wins over the one in writeback
    always_comb begin
        if (fwd_hit(exe_fwd_o.valid, exe_fwd_o.we, exe_fwd_o.waddr, dec_i.rs1)) begin
            opa = exe_fwd_o.wdata;
        end else if (fwd_hit(wb_fwd_i.valid, wb_fwd_i.we, wb_fwd_i.waddr, dec_i.rs1)) begin
            opa = wb_fwd_i.wdata;
        end else begin
            opa = dec_i.op_a;
        end
        if (fwd_hit(exe_fwd_o.valid, exe_fwd_o.we, exe_fwd_o.waddr, dec_i.rs2)) begin
            opb = exe_fwd_o.wdata;
        end else if (fwd_hit(wb_fwd_i.valid, wb_fwd_i.we, wb_fwd_i.waddr, dec_i.rs2)) begin
            opb = wb_fwd_i.wdata;
        end else begin
            opb = dec_i.op_b;
        end
    end

    assign alu_b = dec_i.use_imm ? dec_i.imm : opb;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD: alu_res = opa + alu_b;
            ALU_SUB: alu_res = opa - alu_b;
            ALU_AND: alu_res = opa & alu_b;
            ALU_OR: alu_res = opa | alu_b;
            ALU_XOR: alu_res = opa ^ alu_b;
            ALU_SLL: alu_res = opa << alu_b[SHAMT_W-1:0];
            ALU_SRL: alu_res = opa >> alu_b[SHAMT_W-1:0];
            default: alu_res = alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q <= 1'b0;
            we_q <= 1'b0;
            excp_q <= 1'b0;
            store_q <= 1'b0;
            cnt_lo_q <= 1'b0;
            cnt_hi_q <= 1'b0;
        end else begin
            valid_q <= dec_i.valid;
            we_q <= dec_i.valid && dec_i.writes_rd;
            excp_q <= dec_i.valid && dec_i.excp;
            store_q <= dec_i.valid && dec_i.is_store;
            cnt_lo_q <= dec_i.is_cnt_lo;
            cnt_hi_q <= dec_i.is_cnt_hi;
        end
    end

    always_ff @(posedge clk) begin
        pc_q <= dec_i.pc;
        instr_q <= dec_i.instr;
        waddr_q <= dec_i.rd;
        res_q <= alu_res;
        st_data_q <= opb;
    end

    // Counter sampled in the cycle before commit
    assign exe_wdata = cnt_hi_q ? cycle_cnt[2*WORD_W-1:WORD_W] :
                       cnt_lo_q ? cycle_cnt[WORD_W-1:0] : res_q;

    assign wb_o.valid = valid_q;
    assign wb_o.pc = pc_q;
    assign wb_o.instr = instr_q;
    assign wb_o.we = we_q;
    assign wb_o.waddr = waddr_q;
    assign wb_o.wdata = exe_wdata;
    assign wb_o.is_store = store_q;
    assign wb_o.st_addr = res_q;
    assign wb_o.st_data = st_data_q;
    assign wb_o.excp = excp_q;

    assign exe_fwd_o.valid = valid_q;
    assign exe_fwd_o.we = we_q;
    assign exe_fwd_o.waddr = waddr_q;
    assign exe_fwd_o.wdata = exe_wdata;

    a_excp_no_we: assert property (@(posedge clk) disable iff (rst)
        wb_o.valid && wb_o.excp |-> !wb_o.we);

endmodule

`default_nettype wire

// File: writeback/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    exe_wb_if.snk               exe_i,
    fwd_if.src                  fwd_o,
    output logic                rf_we_o,
    output pipe_pkg::reg_addr_t rf_waddr_o,
    output pipe_pkg::word_t     rf_wdata_o,
    output logic                commit_valid_o,
    output pipe_pkg::word_t     commit_pc_o,
    output pipe_pkg::word_t     commit_instr_o,
    output logic                commit_we_o,
    output pipe_pkg::reg_addr_t commit_waddr_o,
    output pipe_pkg::word_t     commit_wdata_o,
    output logic                commit_excp_o,
    output logic                store_commit_o,
    output pipe_pkg::word_t     store_addr_o,
    output pipe_pkg::word_t     store_data_o,
    output logic                redirect_o
);
    logic store_q;

    // Register file is written as the instruction enters commit
    assign rf_we_o = exe_i.valid && exe_i.we && !flush_i;
    assign rf_waddr_o = exe_i.waddr;
    assign rf_wdata_o = exe_i.wdata;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            commit_valid_o <= 1'b0;
            commit_we_o <= 1'b0;
            commit_excp_o <= 1'b0;
            store_q <= 1'b0;
        end else begin
            commit_valid_o <= exe_i.valid;
            commit_we_o <= exe_i.valid && exe_i.we;
            commit_excp_o <= exe_i.valid && exe_i.excp;
            store_q <= exe_i.valid && exe_i.is_store;
        end
    end

    always_ff @(posedge clk) begin
        commit_pc_o <= exe_i.pc;
        commit_instr_o <= exe_i.instr;
        commit_waddr_o <= exe_i.waddr;
        commit_wdata_o <= exe_i.wdata;
        store_addr_o <= exe_i.st_addr;
        store_data_o <= exe_i.st_data;
    end

    assign store_commit_o = store_q && !commit_excp_o;
    assign redirect_o = commit_excp_o;

    assign fwd_o.valid = commit_valid_o;
    assign fwd_o.we = commit_we_o;
    assign fwd_o.waddr = commit_waddr_o;
    assign fwd_o.wdata = commit_wdata_o;

    a_strobes: assert property (@(posedge clk) disable iff (rst)
        !(store_commit_o && redirect_o) && ((store_commit_o || redirect_o) -> commit_valid_o));

endmodule

`default_nettype wire

// File: source/pipe_tail_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_tail_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid_i,
    input  pipe_pkg::word_t     instr_i,
    input  pipe_pkg::word_t     pc_i,
    input  logic                flush_i,
    output logic                commit_valid_o,
    output pipe_pkg::word_t     commit_pc_o,
    output pipe_pkg::word_t     commit_instr_o,
    output logic                commit_we_o,
    output pipe_pkg::reg_addr_t commit_waddr_o,
    output pipe_pkg::word_t     commit_wdata_o,
    output logic                commit_excp_o,
    output logic                store_commit_o,
    output pipe_pkg::word_t     store_addr_o,
    output pipe_pkg::word_t     store_data_o,
    output logic                redirect_o
);
    import pipe_pkg::*;

    reg_addr_t rf_raddr_a;
    reg_addr_t rf_raddr_b;
    word_t     rf_rdata_a;
    word_t     rf_rdata_b;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    dec_exe_if dec_exe ();
    exe_wb_if  exe_wb ();
    fwd_if     exe_fwd ();
    fwd_if     wb_fwd ();

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rf_raddr_a_o  (rf_raddr_a),
        .rf_raddr_b_o  (rf_raddr_b),
        .rf_rdata_a_i  (rf_rdata_a),
        .rf_rdata_b_i  (rf_rdata_b),
        .dec_o         (dec_exe.src)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (flush_i),
        .dec_i     (dec_exe.snk),
        .wb_o      (exe_wb.src),
        .exe_fwd_o (exe_fwd.src),
        .wb_fwd_i  (wb_fwd.snk)
    );

    writeback_stage u_writeback (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .exe_i          (exe_wb.snk),
        .fwd_o          (wb_fwd.src),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_instr_o (commit_instr_o),
        .commit_we_o    (commit_we_o),
        .commit_waddr_o (commit_waddr_o),
        .commit_wdata_o (commit_wdata_o),
        .commit_excp_o  (commit_excp_o),
        .store_commit_o (store_commit_o),
        .store_addr_o   (store_addr_o),
        .store_data_o   (store_data_o),
        .redirect_o     (redirect_o)
    );

endmodule

`default_nettype wire

// File: dv/commit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module commit_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid_i,
    input  pipe_pkg::word_t     instr_i,
    input  pipe_pkg::word_t     pc_i,
    input  logic                flush_i,
    input  logic                commit_valid_i,
    input  pipe_pkg::word_t     commit_pc_i,
    input  pipe_pkg::word_t     commit_instr_i,
    input  logic                commit_we_i,
    input  pipe_pkg::reg_addr_t commit_waddr_i,
    input  pipe_pkg::word_t     commit_wdata_i,
    input  logic                commit_excp_i,
    input  logic                store_commit_i,
    input  pipe_pkg::word_t     store_addr_i,
    input  pipe_pkg::word_t     store_data_i,
    input  logic                redirect_i,
    input  int                  phase_i,
    input  logic                phase_end_i,
    output logic                idle_o,
    output int                  pass_o,
    output int                  fail_o
);
    import pipe_pkg::*;

    typedef struct packed {
        word_t       pc;
        word_t       instr;
        logic [31:0] strobe_edge;
    } entry_t;

    entry_t      pend_q [$];
    word_t       model_regs [NUM_REGS];
    cnt_t        cycle_cnt = '0;
    logic [31:0] edge_no = '0;
    logic        idle_q = 1'b1;
    int          n_pass = 0;
    int          n_fail = 0;
    int          base_pass = 0;
    int          base_fail = 0;

    assign idle_o = idle_q;
    assign pass_o = n_pass;
    assign fail_o = n_fail;

    function automatic string test_name(input int p);
        case (p)
            0: return "alu_random";
            1: return "dependency_chain";
            2: return "store";
            3: return "exception";
            4: return "flush";
            default: return "counter";
        endcase
    endfunction

    task automatic check_word(input string field, input word_t exp, input word_t act);
        if (exp === act) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("mismatch %s %s: expected %h, actual %h",
                     test_name(phase_i), field, exp, act);
        end
    endtask

    task automatic report(input string what);
        n_fail++;
        $display("error in %s: %s", test_name(phase_i), what);
    endtask

    // Runs the oldest pending instruction on the model and compares the commit
    task automatic check_commit();
        entry_t           e;
        logic [5:0]       opc;
        reg_addr_t        rd;
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        logic [IMM_W-1:0] imm;
        word_t            a;
        word_t            b;
        word_t            sext_imm;
        word_t            exp_wdata;
        word_t            exp_st_addr;
        word_t            exp_st_data;
        logic             exp_we;
        logic             exp_st;
        logic             exp_excp;
        cnt_t             exec_cnt;
        e = pend_q.pop_front();
        opc = e.instr[OPC_HI:OPC_LO];
        rd = e.instr[RD_HI:RD_LO];
        rs1 = e.instr[RS1_HI:RS1_LO];
        rs2 = e.instr[RS2_HI:RS2_LO];
        imm = e.instr[IMM_HI:IMM_LO];
        a = model_regs[rs1];
        b = model_regs[rs2];
        sext_imm = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
        // Count of the execute cycle, one before the commit cycle
        exec_cnt = cycle_cnt - 64'd1;
        exp_wdata = '0;
        exp_st_addr = '0;
        exp_st_data = '0;
        exp_we = 1'b1;
        exp_st = 1'b0;
        exp_excp = 1'b0;
        case (opc)
            OP_ADD: exp_wdata = a + b;
            OP_SUB: exp_wdata = a - b;
            OP_AND: exp_wdata = a & b;
            OP_OR: exp_wdata = a | b;
            OP_XOR: exp_wdata = a ^ b;
            OP_SLL: exp_wdata = a << b[4:0];
            OP_SRL: exp_wdata = a >> b[4:0];
            OP_ADDI: exp_wdata = a + sext_imm;
            OP_LUI: exp_wdata = {imm, 16'h0000};
            OP_ST: begin
                exp_we = 1'b0;
                exp_st = 1'b1;
                exp_st_addr = a + sext_imm;
                exp_st_data = model_regs[rd];
            end
            OP_RDCNT_LO: exp_wdata = exec_cnt[31:0];
            OP_RDCNT_HI: exp_wdata = exec_cnt[63:32];
            default: begin
                exp_we = 1'b0;
                exp_excp = 1'b1;
            end
        endcase
        check_word("pc", e.pc, commit_pc_i);
        check_word("instr", e.instr, commit_instr_i);
        check_word("latency", 32'd3, edge_no - e.strobe_edge);
        check_word("we", 32'(exp_we), 32'(commit_we_i));
        check_word("excp", 32'(exp_excp), 32'(commit_excp_i));
        check_word("redirect", 32'(exp_excp), 32'(redirect_i));
        check_word("store_commit", 32'(exp_st), 32'(store_commit_i));
        if (exp_we) begin
            check_word("waddr", 32'(rd), 32'(commit_waddr_i));
            check_word("wdata", exp_wdata, commit_wdata_i);
            if (rd != REG_ZERO) begin
                model_regs[rd] = exp_wdata;
            end
        end
        if (exp_st) begin
            check_word("store_addr", exp_st_addr, store_addr_i);
            check_word("store_data", exp_st_data, store_data_i);
        end
    endtask

    task automatic end_phase();
        if (pend_q.size() != 0) begin
            report($sformatf("%0d issued instructions never committed", pend_q.size()));
            pend_q.delete();
        end
        $display("test %s finished: %0d checks passed, %0d failed",
                 test_name(phase_i), n_pass - base_pass, n_fail - base_fail);
        base_pass = n_pass;
        base_fail = n_fail;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pend_q.delete();
            for (int i = 0; i < NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (commit_valid_i) begin
                if (pend_q.size() == 0) begin
                    report($sformatf("commit of pc %h with no instruction pending",
                                     commit_pc_i));
                end else begin
                    check_commit();
                end
            end else if (store_commit_i || redirect_i) begin
                report("store or redirect strobe without a commit");
            end
            // Flush drops everything not yet committed, this cycle's strobe too
            if (flush_i) begin
                pend_q.delete();
            end else if (instr_valid_i) begin
                pend_q.push_back('{pc: pc_i, instr: instr_i, strobe_edge: edge_no});
            end
            if (phase_end_i) begin
                end_phase();
            end
        end
        cycle_cnt = rst ? '0 : cycle_cnt + 64'd1;
        edge_no = edge_no + 32'd1;
        idle_q <= (pend_q.size() == 0);
    end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import pipe_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PHASES = 6;
    localparam int PHASE_INSTRS = 200;
    localparam int PHASE_CYCLES = 210;
    localparam int DRAIN_CYCLES = 8;
    localparam int SEED = 32'h4f86;
    localparam int TIMEOUT_NS = 2 * (RESET_CYCLES + NUM_PHASES * PHASE_CYCLES) * CLK_PERIOD;

    localparam logic [5:0] ALU_OPS [9] = '{
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_ADDI, OP_LUI
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    word_t       instr;
    word_t       pc;
    logic        flush;
    logic        commit_valid;
    word_t       commit_pc;
    word_t       commit_instr;
    logic        commit_we;
    reg_addr_t   commit_waddr;
    word_t       commit_wdata;
    logic        commit_excp;
    logic        store_commit;
    word_t       store_addr;
    word_t       store_data;
    logic        redirect;
    int          phase;
    logic        phase_end;
    logic        idle;
    int          n_pass;
    int          n_fail;
    word_t       next_pc;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipe_tail_top uut (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .pc_i           (pc),
        .flush_i        (flush),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .commit_instr_o (commit_instr),
        .commit_we_o    (commit_we),
        .commit_waddr_o (commit_waddr),
        .commit_wdata_o (commit_wdata),
        .commit_excp_o  (commit_excp),
        .store_commit_o (store_commit),
        .store_addr_o   (store_addr),
        .store_data_o   (store_data),
        .redirect_o     (redirect)
    );

    commit_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .pc_i           (pc),
        .flush_i        (flush),
        .commit_valid_i (commit_valid),
        .commit_pc_i    (commit_pc),
        .commit_instr_i (commit_instr),
        .commit_we_i    (commit_we),
        .commit_waddr_i (commit_waddr),
        .commit_wdata_i (commit_wdata),
        .commit_excp_i  (commit_excp),
        .store_commit_i (store_commit),
        .store_addr_i   (store_addr),
        .store_data_i   (store_data),
        .redirect_i     (redirect),
        .phase_i        (phase),
        .phase_end_i    (phase_end),
        .idle_o         (idle),
        .pass_o         (n_pass),
        .fail_o         (n_fail)
    );

    function automatic word_t encode(input logic [5:0] opc, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [15:0] low);
        word_t w;
        w[OPC_HI:OPC_LO] = opc;
        w[RD_HI:RD_LO] = rd;
        w[RS1_HI:RS1_LO] = rs1;
        w[IMM_HI:IMM_LO] = low;
        return w;
    endfunction

    function automatic reg_addr_t pick_reg(input int max_reg);
        return 5'($urandom_range(max_reg, 0));
    endfunction

    function automatic word_t random_alu(input int max_reg);
        logic [3:0] k;
        logic [5:0] opc;
        word_t      w;
        k = 4'($urandom_range(8, 0));
        opc = ALU_OPS[k];
        w = encode(opc, pick_reg(max_reg), pick_reg(max_reg), 16'($urandom()));
        if (opc != OP_ADDI && opc != OP_LUI) begin
            w[RS2_HI:RS2_LO] = pick_reg(max_reg);
        end
        return w;
    endfunction

    function automatic word_t random_store();
        return encode(OP_ST, pick_reg(7), pick_reg(7), 16'($urandom()));
    endfunction

    // Code zero and everything above the last opcode
    function automatic word_t random_illegal();
        logic [5:0] opc;
        if ($urandom_range(3, 0) == 0) begin
            opc = 6'h00;
        end else begin
            opc = 6'($urandom_range(63, int'(OP_RDCNT_HI) + 1));
        end
        return encode(opc, pick_reg(7), pick_reg(7), 16'($urandom()));
    endfunction

    function automatic word_t random_counter_read();
        logic [5:0] opc;
        opc = ($urandom_range(1, 0) == 1) ? OP_RDCNT_HI : OP_RDCNT_LO;
        return encode(opc, pick_reg(7), pick_reg(7), 16'($urandom()));
    endfunction

    function automatic word_t next_instr(input int ph);
        int pick;
        pick = $urandom_range(9, 0);
        case (ph)
            0: return random_alu(31);
            1: return random_alu(3);
            2: return (pick < 5) ? random_store() : random_alu(7);
            3: return (pick < 3) ? random_illegal() : random_alu(7);
            4: begin
                if (pick < 2) return random_store();
                if (pick < 3) return random_illegal();
                return random_alu(7);
            end
            default: return (pick < 4) ? random_counter_read() : random_alu(7);
        endcase
    endfunction

    task automatic drive(input logic valid, input word_t word, input logic fl, input logic pend);
        @(negedge clk);
        instr_valid = valid;
        instr = word;
        pc = next_pc;
        flush = fl;
        phase_end = pend;
        if (valid) begin
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic run_phase(input int ph);
        int   gap;
        logic fl;
        phase = ph;
        for (int i = 0; i < PHASE_INSTRS; i++) begin
            fl = (ph == 4) && ($urandom_range(9, 0) == 0);
            drive(1'b1, next_instr(ph), fl, 1'b0);
            gap = 0;
            if (ph == 0) begin
                gap = $urandom_range(2, 0);
            end else if (ph == 5) begin
                gap = $urandom_range(1, 0);
            end
            for (int g = 0; g < gap; g++) begin
                drive(1'b0, $urandom(), 1'b0, 1'b0);
            end
        end
        drive(1'b0, $urandom(), 1'b0, 1'b0);
        for (int w = 0; w < DRAIN_CYCLES && !idle; w++) begin
            drive(1'b0, $urandom(), 1'b0, 1'b0);
        end
        drive(1'b0, $urandom(), 1'b0, 1'b1);
        drive(1'b0, $urandom(), 1'b0, 1'b0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        flush = 1'b0;
        phase = 0;
        phase_end = 1'b0;
        next_pc = 32'h1c00_0000;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            run_phase(p);
        end
        repeat (4) @(negedge clk);
        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/pipe_pkg.sv
common/pipe_ifs.sv
source/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
writeback/writeback_stage.sv
source/pipe_tail_top.sv
dv/commit_checker.sv
dv/tb_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --timescale 1ns/1ps \
    --top-module tb_top --Mdir obj_dir -f filelist.f

./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
